//--- logic/ball_physics.sv
// Ball position and direction, wall and paddle bounces, per-frame hit or miss event
module ball_physics (
	input  logic                  Clock_25,
	input  logic                  system_resetn,
	input  logic                  frame_start,
	input  logic                  restart,
	input  logic                  game_over,
	input  pong_pkg::speed_t      speed,
	input  logic                  serve_x_dir,
	input  logic                  serve_y_dir,
	input  pong_pkg::coord_t      bar_x,
	output pong_pkg::coord_t      ball_x,
	output pong_pkg::coord_t      ball_y,
	output pong_pkg::ball_event_e ball_event
);

pong_pkg::coord_t step;
logic moving_right;
logic moving_down;
logic right_ok;
logic left_ok;
logic up_ok;
logic down_ok;
logic on_paddle;
logic active_frame;

assign step = pong_pkg::coord_t'(speed);
assign active_frame = frame_start & ~game_over;

// Room for one more step in each direction
assign right_ok = ball_x < pong_pkg::H_ACTIVE - pong_pkg::OBJECT_SIZE - step;
assign left_ok  = ball_x >= step;
assign up_ok    = ball_y >= step;
assign down_ok  = ball_y <= pong_pkg::BAR_Y - pong_pkg::OBJECT_SIZE - step;

// Both ball edges inside the paddle span
assign on_paddle = (ball_x >= bar_x)
	&& (ball_x + pong_pkg::OBJECT_SIZE <= bar_x + pong_pkg::BAR_WIDTH);

// Outcome only exists on the frame edge while descending onto the paddle row
always_comb begin
	ball_event = pong_pkg::NONE;
	if (active_frame && moving_down && !down_ok) begin
		if (on_paddle)
			ball_event = pong_pkg::HIT;
		else
			ball_event = pong_pkg::MISS;
	end
end

always_ff @ (posedge Clock_25 or negedge system_resetn) begin
	if (system_resetn == 1'b0) begin
		ball_x <= pong_pkg::SERVE_X;
		ball_y <= pong_pkg::SERVE_Y;
		moving_right <= 1'b1;
		moving_down <= 1'b1;
	end else if (restart && game_over) begin
		// New game serve is always right and down
		ball_x <= pong_pkg::SERVE_X;
		ball_y <= pong_pkg::SERVE_Y;
		moving_right <= 1'b1;
		moving_down <= 1'b1;
	end else if (ball_event == pong_pkg::MISS) begin
		// Serve again, last miss included
		ball_x <= pong_pkg::SERVE_X;
		ball_y <= pong_pkg::SERVE_Y;
		moving_right <= serve_x_dir;
		moving_down <= serve_y_dir;
	end else if (active_frame) begin
		if (moving_right) begin
			if (right_ok)
				ball_x <= ball_x + step;
			else
				moving_right <= 1'b0; // Right wall
		end else begin
			if (left_ok)
				ball_x <= ball_x - step;
			else
				moving_right <= 1'b1; // Left wall
		end

		if (moving_down) begin
			if (down_ok)
				ball_y <= ball_y + step;
			else
				moving_down <= 1'b0; // Only reached on a paddle hit
		end else begin
			if (up_ok)
				ball_y <= ball_y - step;
			else
				moving_down <= 1'b1; // Top wall
		end
	end
end

endmodule

//--- logic/frame_sync.sv
// Vsync falling edge detect, restart switch toggle detect, paddle command encoder
module frame_sync (
	input  logic                  Clock_25,
	input  logic                  system_resetn,
	input  logic                  vsync,
	input  logic                  restart_sw,
	input  logic                  btn_right,
	input  logic                  btn_left,
	output logic                  frame_start,
	output logic                  restart,
	output pong_pkg::paddle_cmd_e paddle_cmd
);

logic vsync_buf;
logic restart_sw_buf;

always_ff @ (posedge Clock_25 or negedge system_resetn) begin
	if (system_resetn == 1'b0) begin
		vsync_buf <= 1'b0;
		restart_sw_buf <= 1'b0;
	end else begin
		vsync_buf <= vsync;
		restart_sw_buf <= restart_sw;
	end
end

// Start of vertical blanking
assign frame_start = vsync_buf & ~vsync;

// Either direction of the switch counts
assign restart = restart_sw ^ restart_sw_buf;

// Right button wins when both are held
always_comb begin
	paddle_cmd = pong_pkg::HOLD;
	if (btn_right) begin
		paddle_cmd = pong_pkg::RIGHT;
	end else if (btn_left) begin
		paddle_cmd = pong_pkg::LEFT;
	end
end

endmodule

//--- logic/paddle_tracker.sv
// Paddle column register, stepped once per frame within the screen limits
module paddle_tracker (
	input  logic                  Clock_25,
	input  logic                  system_resetn,
	input  logic                  frame_start,
	input  pong_pkg::paddle_cmd_e paddle_cmd,
	output pong_pkg::coord_t      bar_x
);

// Paddle keeps following the buttons during game over
always_ff @ (posedge Clock_25 or negedge system_resetn) begin
	if (system_resetn == 1'b0) begin
		bar_x <= pong_pkg::BAR_START_X;
	end else if (frame_start) begin
		case (paddle_cmd)
			pong_pkg::RIGHT: begin
				// Step only while the paddle stays within column 575
				if (bar_x < pong_pkg::H_ACTIVE - pong_pkg::BAR_WIDTH - pong_pkg::BAR_SPEED)
					bar_x <= bar_x + pong_pkg::BAR_SPEED;
			end
			pong_pkg::LEFT: begin
				if (bar_x > pong_pkg::BAR_SPEED)
					bar_x <= bar_x - pong_pkg::BAR_SPEED;
			end
			default: begin
				bar_x <= bar_x; // Hold
			end
		endcase
	end
end

endmodule

//--- logic/pong_core.sv
// Top level of the game engine, frame conditioning, motion and scoring blocks
module pong_core (
	input  logic                Clock_25,
	input  logic                system_resetn,
	input  logic                vsync,
	input  logic                btn_right,
	input  logic                btn_left,
	input  pong_pkg::speed_t    speed,
	input  logic                serve_x_dir,
	input  logic                serve_y_dir,
	input  logic                restart_sw,
	input  pong_pkg::rank_idx_t rank_index,
	output pong_pkg::coord_t    ball_x,
	output pong_pkg::coord_t    ball_y,
	output pong_pkg::coord_t    bar_x,
	output pong_pkg::bcd2_t     score,
	output pong_pkg::lives_t    lives,
	output logic                game_over,
	output pong_pkg::bcd2_t     rank_score,
	output pong_pkg::bcd2_t     rank_game
);

logic frame_start;
logic restart;
logic rank_insert;
pong_pkg::paddle_cmd_e paddle_cmd;
pong_pkg::ball_event_e ball_event;
pong_pkg::bcd2_t game_number;

frame_sync u_frame_sync (
	.Clock_25      (Clock_25),
	.system_resetn (system_resetn),
	.vsync         (vsync),
	.restart_sw    (restart_sw),
	.btn_right     (btn_right),
	.btn_left      (btn_left),
	.frame_start   (frame_start),
	.restart       (restart),
	.paddle_cmd    (paddle_cmd)
);

paddle_tracker u_paddle_tracker (
	.Clock_25      (Clock_25),
	.system_resetn (system_resetn),
	.frame_start   (frame_start),
	.paddle_cmd    (paddle_cmd),
	.bar_x         (bar_x)
);

ball_physics u_ball_physics (
	.Clock_25      (Clock_25),
	.system_resetn (system_resetn),
	.frame_start   (frame_start),
	.restart       (restart),
	.game_over     (game_over),
	.speed         (speed),
	.serve_x_dir   (serve_x_dir),
	.serve_y_dir   (serve_y_dir),
	.bar_x         (bar_x),
	.ball_x        (ball_x),
	.ball_y        (ball_y),
	.ball_event    (ball_event)
);

scoreboard u_scoreboard (
	.Clock_25      (Clock_25),
	.system_resetn (system_resetn),
	.restart       (restart),
	.ball_event    (ball_event),
	.score         (score),
	.lives         (lives),
	.game_over     (game_over),
	.rank_insert   (rank_insert),
	.game_number   (game_number)
);

rank_table u_rank_table (
	.Clock_25      (Clock_25),
	.system_resetn (system_resetn),
	.rank_insert   (rank_insert),
	.score         (score),
	.game_number   (game_number),
	.rank_index    (rank_index),
	.rank_score    (rank_score),
	.rank_game     (rank_game)
);

endmodule

//--- logic/pong_pkg.sv
// Screen geometry, game constants, type widths and the game enums
package pong_pkg;

	// Type widths
	localparam int COORD_W    = 10;
	localparam int SPEED_W    = 3;
	localparam int LIVES_W    = 2;
	localparam int BCD2_W     = 8;
	localparam int RANK_IDX_W = 4;

	typedef logic [COORD_W-1:0]    coord_t;
	typedef logic [SPEED_W-1:0]    speed_t;
	typedef logic [LIVES_W-1:0]    lives_t;
	typedef logic [BCD2_W-1:0]     bcd2_t;     // Tens digit in [7:4]
	typedef logic [RANK_IDX_W-1:0] rank_idx_t;

	typedef enum logic [1:0] {HOLD, RIGHT, LEFT} paddle_cmd_e;
	typedef enum logic [1:0] {NONE, HIT, MISS} ball_event_e;
	typedef enum logic [1:0] {PLAY, RANKING, OVER} game_state_e;

	// Visible area
	localparam coord_t H_ACTIVE = 10'd640;
	localparam coord_t V_ACTIVE = 10'd480;

	// Ball and paddle
	localparam coord_t OBJECT_SIZE   = 10'd10;
	localparam coord_t BAR_WIDTH     = 10'd60;
	localparam coord_t BAR_HEIGHT    = 10'd5;
	localparam coord_t BAR_SPEED     = 10'd5;
	localparam coord_t BOTTOM_MARGIN = 10'd50;
	localparam coord_t BAR_Y         = V_ACTIVE - BAR_HEIGHT - BOTTOM_MARGIN; // Row 425
	localparam coord_t BAR_START_X   = 10'd200;
	localparam coord_t SERVE_X       = 10'd200;
	localparam coord_t SERVE_Y       = 10'd50;

	// Game rules
	localparam lives_t START_LIVES = 2'd3;
	localparam int     RANK_DEPTH  = 10;

endpackage

//--- logic/rank_table.sv
// Descending high-score table with ordered insertion and indexed readout
module rank_table (
	input  logic                Clock_25,
	input  logic                system_resetn,
	input  logic                rank_insert,
	input  pong_pkg::bcd2_t     score,
	input  pong_pkg::bcd2_t     game_number,
	input  pong_pkg::rank_idx_t rank_index,
	output pong_pkg::bcd2_t     rank_score,
	output pong_pkg::bcd2_t     rank_game
);

pong_pkg::bcd2_t score_q [pong_pkg::RANK_DEPTH];
pong_pkg::bcd2_t game_q  [pong_pkg::RANK_DEPTH];
logic [pong_pkg::RANK_DEPTH-1:0] take_slot;

// BCD orders like binary, so a plain compare works
// Table stays sorted, so take_slot is a thermometer from the insert point down
always_comb begin
	for (int i = 0; i < pong_pkg::RANK_DEPTH; i++) begin
		take_slot[i] = (score_q[i] <= score);
	end
end

always_ff @ (posedge Clock_25 or negedge system_resetn) begin
	if (system_resetn == 1'b0) begin
		for (int i = 0; i < pong_pkg::RANK_DEPTH; i++) begin
			score_q[i] <= 8'h00;
			game_q[i] <= 8'h00;
		end
	end else if (rank_insert) begin
		if (take_slot[0]) begin
			score_q[0] <= score;
			game_q[0] <= game_number;
		end
		for (int i = 1; i < pong_pkg::RANK_DEPTH; i++) begin
			if (take_slot[i] && !take_slot[i-1]) begin
				// Insert point, newer entry ahead of equal scores
				score_q[i] <= score;
				game_q[i] <= game_number;
			end else if (take_slot[i]) begin
				score_q[i] <= score_q[i-1]; // Shift down, last entry drops off
				game_q[i] <= game_q[i-1];
			end
		end
	end
end

// Out-of-range index reads as zero
always_comb begin
	rank_score = 8'h00;
	rank_game = 8'h00;
	if (rank_index < pong_pkg::RANK_DEPTH) begin
		rank_score = score_q[rank_index];
		rank_game = game_q[rank_index];
	end
end

endmodule

//--- logic/scoreboard.sv
// Game FSM with BCD score, lives, rank insert strobe and BCD game counter
module scoreboard (
	input  logic                  Clock_25,
	input  logic                  system_resetn,
	input  logic                  restart,
	input  pong_pkg::ball_event_e ball_event,
	output pong_pkg::bcd2_t       score,
	output pong_pkg::lives_t      lives,
	output logic                  game_over,
	output logic                  rank_insert,
	output pong_pkg::bcd2_t       game_number
);

pong_pkg::game_state_e state;

// Two-digit BCD increment, 99 wraps to 00
function automatic pong_pkg::bcd2_t bcd2_inc(input pong_pkg::bcd2_t value);
	pong_pkg::bcd2_t result;
	result = value;
	if (value[3:0] == 4'd9) begin
		result[3:0] = 4'd0;
		if (value[7:4] == 4'd9)
			result[7:4] = 4'd0;
		else
			result[7:4] = value[7:4] + 4'd1;
	end else begin
		result[3:0] = value[3:0] + 4'd1;
	end
	return result;
endfunction

always_ff @ (posedge Clock_25 or negedge system_resetn) begin
	if (system_resetn == 1'b0) begin
		state <= pong_pkg::PLAY;
		score <= 8'h00;
		lives <= pong_pkg::START_LIVES;
		game_number <= 8'h00;
	end else begin
		case (state)
			pong_pkg::PLAY: begin
				if (ball_event == pong_pkg::HIT) begin
					score <= bcd2_inc(score);
				end else if (ball_event == pong_pkg::MISS) begin
					lives <= lives - 2'd1;
					if (lives == 2'd1) begin
						// Last life gone, game is finished
						state <= pong_pkg::RANKING;
						game_number <= bcd2_inc(game_number);
					end
				end
			end
			pong_pkg::RANKING: state <= pong_pkg::OVER; // One cycle for the table write
			pong_pkg::OVER: begin
				if (restart) begin
					state <= pong_pkg::PLAY;
					score <= 8'h00;
					lives <= pong_pkg::START_LIVES;
				end
			end
			default: state <= pong_pkg::PLAY;
		endcase
	end
end

assign game_over = (state != pong_pkg::PLAY);
assign rank_insert = (state == pong_pkg::RANKING);

endmodule

//--- verif/pong_assert.sv
// Bound concurrent assertions on score, lives, positions and game over of the top level
module pong_assert (
	input logic             Clock_25,
	input logic             system_resetn,
	input logic             restart_sw,
	input logic             game_over,
	input pong_pkg::bcd2_t  score,
	input pong_pkg::lives_t lives,
	input pong_pkg::coord_t bar_x,
	input pong_pkg::coord_t ball_x
);
timeunit 1ns;
timeprecision 100ps;

int assert_errors = 0;

task automatic raise_error(input string what);
	assert_errors++;
	$error("%s", what);
endtask

assert property (@(posedge Clock_25) disable iff (!system_resetn)
	score[3:0] <= 4'd9 && score[7:4] <= 4'd9)
	else raise_error("score digit above 9");

// Lives only reach zero together with the end of the game
assert property (@(posedge Clock_25) disable iff (!system_resetn)
	!game_over |-> lives inside {[2'd1:2'd3]})
	else raise_error("lives outside 1 to 3 during play");

assert property (@(posedge Clock_25) disable iff (!system_resetn) bar_x <= 10'd575)
	else raise_error("bar_x beyond column 575");

assert property (@(posedge Clock_25) disable iff (!system_resetn) ball_x <= 10'd630)
	else raise_error("ball_x beyond column 630");

// Switch change is seen one edge before game_over drops
assert property (@(posedge Clock_25) disable iff (!system_resetn)
	$fell(game_over) |-> $past(restart_sw, 1) != $past(restart_sw, 2))
	else raise_error("game_over fell without a restart_sw change");

endmodule

bind pong_core pong_assert u_pong_assert (.*);

//--- verif/pong_checker.sv
// Reference model of the game rules, output comparisons and per-test report
module pong_checker (
	input  logic                Clock_25,
	input  logic                system_resetn,
	input  logic                vsync,
	input  logic                btn_right,
	input  logic                btn_left,
	input  pong_pkg::speed_t    speed,
	input  logic                serve_x_dir,
	input  logic                serve_y_dir,
	input  logic                restart_sw,
	input  pong_pkg::rank_idx_t rank_index,
	input  logic                rank_sweep,
	input  logic                test_done,
	input  logic [8*12-1:0]     test_name,
	input  pong_pkg::coord_t    ball_x,
	input  pong_pkg::coord_t    ball_y,
	input  pong_pkg::coord_t    bar_x,
	input  pong_pkg::bcd2_t     score,
	input  pong_pkg::lives_t    lives,
	input  logic                game_over,
	input  pong_pkg::bcd2_t     rank_score,
	input  pong_pkg::bcd2_t     rank_game,
	output int                  tests_passed,
	output int                  tests_failed,
	output int                  mismatches
);
timeunit 1ns;
timeprecision 100ps;

// Model state, counts held in binary
int m_bx;
int m_by;
int m_bar;
int m_score;
int m_lives;
int m_games;
int m_state; // 0 play, 1 ranking, 2 over
logic m_right;
logic m_down;
int tbl_score [pong_pkg::RANK_DEPTH];
int tbl_game [pong_pkg::RANK_DEPTH];
logic vs_prev;
logic rs_prev;
int age; // Edges since the last frame edge
int test_checks;
int test_errors;

function automatic logic [7:0] to_bcd(input int value);
	return {4'(value / 10), 4'(value % 10)};
endfunction

task automatic expect_value(input string sig, input int expected, input int actual);
	test_checks++;
	if (expected != actual) begin
		$display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", sig, expected, actual);
		test_errors++;
		mismatches++;
	end
endtask

task automatic serve(input logic right, input logic down);
	m_bx = pong_pkg::SERVE_X;
	m_by = pong_pkg::SERVE_Y;
	m_right = right;
	m_down = down;
endtask

// First slot scoring at most the new score, rest slides down
task automatic insert_rank();
	int pos;
	pos = pong_pkg::RANK_DEPTH;
	for (int i = pong_pkg::RANK_DEPTH - 1; i >= 0; i--)
		if (tbl_score[i] <= m_score)
			pos = i;
	for (int i = pong_pkg::RANK_DEPTH - 1; i > pos; i--) begin
		tbl_score[i] = tbl_score[i-1];
		tbl_game[i] = tbl_game[i-1];
	end
	if (pos < pong_pkg::RANK_DEPTH) begin
		tbl_score[pos] = m_score;
		tbl_game[pos] = m_games;
	end
endtask

// Compares see the DUT values from before this edge, then the model steps
always @(posedge Clock_25 or negedge system_resetn) begin
	logic frame;
	logic toggled;
	logic hit;
	logic miss;
	int step;
	if (!system_resetn) begin
		serve(1'b1, 1'b1);
		m_bar = pong_pkg::BAR_START_X;
		m_score = 0;
		m_lives = pong_pkg::START_LIVES;
		m_games = 0;
		m_state = 0;
		foreach (tbl_score[i]) begin
			tbl_score[i] = 0;
			tbl_game[i] = 0;
		end
		vs_prev = 1'b0;
		rs_prev = 1'b0;
		age = 1; // Reset values checked like a frame
		test_checks = 0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		mismatches = 0;
	end else begin
		if (age == 3) begin
			expect_value("ball_x", m_bx, ball_x);
			expect_value("ball_y", m_by, ball_y);
			expect_value("bar_x", m_bar, bar_x);
			expect_value("score", to_bcd(m_score), score);
			expect_value("lives", m_lives, lives);
			expect_value("game_over", m_state != 0, game_over);
		end
		if (rank_sweep && rank_index < pong_pkg::RANK_DEPTH) begin
			expect_value("rank_score", to_bcd(tbl_score[rank_index]), rank_score);
			expect_value("rank_game", to_bcd(tbl_game[rank_index]), rank_game);
		end
		if (test_done) begin
			$display("Test %0s: %0d checks, %0d errors, %0s", test_name, test_checks,
				test_errors, test_errors == 0 ? "ok" : "failed");
			if (test_errors == 0)
				tests_passed++;
			else
				tests_failed++;
			test_checks = 0;
			test_errors = 0;
		end

		frame = vs_prev && !vsync;
		toggled = (restart_sw != rs_prev);
		step = speed;
		hit = 1'b0;
		miss = 1'b0;
		// Descent blocked at the paddle row
		if (frame && m_state == 0 && m_down
			&& m_by > pong_pkg::BAR_Y - pong_pkg::OBJECT_SIZE - step) begin
			if (m_bx >= m_bar && m_bx + pong_pkg::OBJECT_SIZE <= m_bar + pong_pkg::BAR_WIDTH)
				hit = 1'b1;
			else
				miss = 1'b1;
		end

		if (toggled && m_state != 0)
			serve(1'b1, 1'b1);
		else if (miss)
			serve(serve_x_dir, serve_y_dir);
		else if (frame && m_state == 0) begin
			if (m_right && m_bx < pong_pkg::H_ACTIVE - pong_pkg::OBJECT_SIZE - step)
				m_bx += step;
			else if (m_right)
				m_right = 1'b0;
			else if (m_bx >= step)
				m_bx -= step;
			else
				m_right = 1'b1;
			if (m_down && hit)
				m_down = 1'b0;
			else if (m_down)
				m_by += step;
			else if (m_by >= step)
				m_by -= step;
			else
				m_down = 1'b1;
		end

		if (frame && btn_right) begin
			if (m_bar < pong_pkg::H_ACTIVE - pong_pkg::BAR_WIDTH - pong_pkg::BAR_SPEED)
				m_bar += pong_pkg::BAR_SPEED;
		end else if (frame && btn_left && m_bar > pong_pkg::BAR_SPEED)
			m_bar -= pong_pkg::BAR_SPEED;

		case (m_state)
			0: begin
				if (hit)
					m_score = (m_score + 1) % 100;
				else if (miss) begin
					m_lives--;
					if (m_lives == 0) begin
						m_state = 1;
						m_games = (m_games + 1) % 100;
					end
				end
			end
			1: begin
				insert_rank();
				m_state = 2;
			end
			default: begin
				if (toggled) begin
					m_score = 0;
					m_lives = pong_pkg::START_LIVES;
					m_state = 0;
				end
			end
		endcase

		vs_prev = vsync;
		rs_prev = restart_sw;
		if (frame)
			age = 1;
		else if (age < 4)
			age++;
	end
end

endmodule

//--- verif/pong_tb.sv
// Testbench top with clock, reset, button LFSR, stimulus table loop, timeout and the DUT
module pong_tb;
timeunit 1ns;
timeprecision 100ps;

logic Clock_25;
logic system_resetn;
logic vsync;
logic btn_right;
logic btn_left;
pong_pkg::speed_t speed;
logic serve_x_dir;
logic serve_y_dir;
logic restart_sw;
pong_pkg::rank_idx_t rank_index;
pong_pkg::coord_t ball_x;
pong_pkg::coord_t ball_y;
pong_pkg::coord_t bar_x;
pong_pkg::bcd2_t score;
pong_pkg::lives_t lives;
logic game_over;
pong_pkg::bcd2_t rank_score;
pong_pkg::bcd2_t rank_game;
logic rank_sweep;
logic test_done;
logic [8*12-1:0] test_name;
int tests_passed;
int tests_failed;
int mismatches;

// Button mode 0 right, 1 left, 2 LFSR
logic [8*12-1:0] row_name [7];
int row_frames [7];
int row_speed [7];
int row_mode [7];
logic [3:0] row_flags [7]; // Serve x, serve y, restart toggle, rank sweep
logic [15:0] lfsr;
int cycle_count;
int cycle_limit;

pong_core u_pong_core (.*);
pong_checker u_pong_checker (.*);

initial begin
	Clock_25 = 1'b0;
	forever #5 Clock_25 = ~Clock_25;
end

// Galois form, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
	if (state[0])
		return (state >> 1) ^ 16'hB400;
	return state >> 1;
endfunction

task automatic set_row(input int idx, input logic [8*12-1:0] name, input int frames,
	input int spd, input int mode, input logic [3:0] flags);
	row_name[idx] = name;
	row_frames[idx] = frames;
	row_speed[idx] = spd;
	row_mode[idx] = mode;
	row_flags[idx] = flags;
endtask

// 20 cycles per frame, vsync high for 16 and low for 4
task automatic run_frame(input int mode, input logic sweep);
	for (int c = 0; c < 20; c++) begin
		@(negedge Clock_25);
		if (c == 0 && mode == 2) begin
			btn_right = lfsr[0];
			lfsr = lfsr_step(lfsr);
			btn_left = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end else if (c == 0) begin
			btn_right = (mode == 0);
			btn_left = (mode == 1);
		end
		vsync = (c < 16);
		if (sweep)
			rank_index = pong_pkg::rank_idx_t'(c % 10);
	end
endtask

always @(posedge Clock_25) begin
	cycle_count++;
	if (cycle_count > cycle_limit) begin
		$display("Timeout: the run did not end within %0d cycles", cycle_limit);
		$display("=== FAIL ===");
		$finish;
	end
end

initial begin
	system_resetn = 1'b0;
	vsync = 1'b0;
	btn_right = 1'b0;
	btn_left = 1'b0;
	speed = '0;
	serve_x_dir = 1'b1;
	serve_y_dir = 1'b1;
	restart_sw = 1'b0;
	rank_index = '0;
	rank_sweep = 1'b0;
	test_done = 1'b0;
	test_name = '0;
	lfsr = 16'd47536;
	cycle_count = 0;
	set_row(0, "reset_sweep", 4, 5, 0, 4'b1101);
	set_row(1, "chase_right", 90, 5, 0, 4'b1000); // Paddle tracks the ball onto a hit
	set_row(2, "lfsr_fast", 220, 7, 2, 4'b0100);
	set_row(3, "wall_left", 160, 3, 1, 4'b0110);
	set_row(4, "lfsr_slow", 260, 3, 2, 4'b1110);
	set_row(5, "right_fast", 200, 7, 0, 4'b1110);
	set_row(6, "rank_check", 6, 7, 2, 4'b1111);
	cycle_limit = 8 + 200;
	foreach (row_frames[t])
		cycle_limit += row_frames[t] * 20;
	repeat (8) @(negedge Clock_25);
	system_resetn = 1'b1;
	foreach (row_frames[t]) begin
		test_name = row_name[t];
		speed = pong_pkg::speed_t'(row_speed[t]);
		serve_x_dir = row_flags[t][3];
		serve_y_dir = row_flags[t][2];
		rank_sweep = row_flags[t][0];
		rank_index = '0;
		if (row_flags[t][1]) begin
			@(negedge Clock_25);
			restart_sw = ~restart_sw;
		end
		repeat (row_frames[t]) run_frame(row_mode[t], row_flags[t][0]);
		@(negedge Clock_25);
		test_done = 1'b1;
		@(negedge Clock_25);
		test_done = 1'b0;
	end
	@(negedge Clock_25);
	$display("Summary: %0d tests passed, %0d tests failed, %0d mismatches, %0d assertion errors",
		tests_passed, tests_failed, mismatches, u_pong_core.u_pong_assert.assert_errors);
	if (tests_passed == $size(row_frames) && tests_failed == 0 && mismatches == 0
		&& u_pong_core.u_pong_assert.assert_errors == 0)
		$display("=== PASS ===");
	else
		$display("=== FAIL ===");
	$finish;
end

endmodule

//--- vlog.f
logic/pong_pkg.sv
logic/frame_sync.sv
logic/paddle_tracker.sv
logic/ball_physics.sv
logic/scoreboard.sv
logic/rank_table.sv
logic/pong_core.sv
verif/pong_assert.sv
verif/pong_checker.sv
verif/pong_tb.sv
